// File: build.f
hdl/div_pkg.sv
hdl/div_stage_if.sv
hdl/div_operand_prep.sv
hdl/div_stage.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
tests/div_asserts.sv
tests/div_checker.sv
tests/div_tb.sv

// File: hdl/div_operand_prep.sv
module div_operand_prep import div_pkg::*; #(
    parameter int XLEN_P = XLEN
) (
    input  logic              clk,
    input  logic              rst_clk,
    input  logic              flush,
    input  logic              advance,
    input  logic              in_valid,
    input  div_op_e           in_op,
    input  logic              in_word,
    input  logic [TAG_W-1:0]  in_tag,
    input  logic [XLEN_P-1:0] in_dividend,
    input  logic [XLEN_P-1:0] in_divisor,
    div_stage_if.sender       out_slot
);

    logic              acc_valid;
    div_op_e           acc_op;
    logic              acc_word;
    logic [TAG_W-1:0]  acc_tag;
    logic [XLEN_P-1:0] acc_dividend;
    logic [XLEN_P-1:0] acc_divisor;

    logic              is_signed;
    logic [XLEN_P-1:0] ext_dividend;
    logic [XLEN_P-1:0] ext_divisor;
    logic              dividend_neg;
    logic              divisor_neg;

    function automatic logic [XLEN_P-1:0] extend_word(input logic [XLEN_P-1:0] value,
                                                      input logic            sgn);
        logic fill;
        fill = sgn & value[WORD_W-1];
        return {{(XLEN_P-WORD_W){fill}}, value[WORD_W-1:0]};
    endfunction

    // Accepted operation, raw operands
    always_ff @(posedge clk or negedge rst_clk) begin
        if (!rst_clk) begin
            acc_valid <= 1'b0;
        end else if (flush) begin
            acc_valid <= 1'b0;
        end else if (advance) begin
            acc_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            acc_op       <= in_op;
            acc_word     <= in_word;
            acc_tag      <= in_tag;
            acc_dividend <= in_dividend;
            acc_divisor  <= in_divisor;
        end
    end

    assign is_signed    = (acc_op == OP_DIV) || (acc_op == OP_REM);
    assign ext_dividend = acc_word ? extend_word(acc_dividend, is_signed) : acc_dividend;
    assign ext_divisor  = acc_word ? extend_word(acc_divisor, is_signed) : acc_divisor;
    assign dividend_neg = is_signed & ext_dividend[XLEN_P-1];
    assign divisor_neg  = is_signed & ext_divisor[XLEN_P-1];

    always_ff @(posedge clk or negedge rst_clk) begin
        if (!rst_clk) begin
            out_slot.valid <= 1'b0;
        end else if (flush) begin
            out_slot.valid <= 1'b0;
        end else if (advance) begin
            out_slot.valid <= acc_valid;
        end
    end

    // Magnitudes go down the pipe, signs travel as flags
    always_ff @(posedge clk) begin
        if (advance) begin
            out_slot.tag           <= acc_tag;
            out_slot.op            <= acc_op;
            out_slot.word          <= acc_word;
            out_slot.neg_quo       <= dividend_neg ^ divisor_neg;
            out_slot.neg_rem       <= dividend_neg;
            out_slot.div_zero      <= (ext_divisor == '0);
            out_slot.orig_dividend <= ext_dividend;
            out_slot.divisor       <= divisor_neg ? -ext_divisor : ext_divisor;
            out_slot.rem           <= '0;
            out_slot.quo           <= dividend_neg ? -ext_dividend : ext_dividend;
        end
    end

endmodule

// File: hdl/div_pkg.sv
package div_pkg;

    // Operand, result and tag widths
    parameter int XLEN   = 64;
    parameter int TAG_W  = 5;

    // Low half used by the word forms
    parameter int WORD_W = 32;

    // Quotient bits resolved per pipeline stage, must divide XLEN
    parameter int BITS_PER_STAGE = 4;
    parameter int NUM_STAGES     = XLEN / BITS_PER_STAGE;

    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_e;

endpackage

// File: hdl/div_result_fix.sv
module div_result_fix import div_pkg::*; #(
    parameter int XLEN_P = XLEN
) (
    input  logic              clk,
    input  logic              rst_clk,
    input  logic              flush,
    div_stage_if.receiver     last,
    input  logic              out_ready,
    output logic              advance,
    output logic              out_valid,
    output logic [TAG_W-1:0]  out_tag,
    output logic [XLEN_P-1:0] out_result
);

    logic [XLEN_P-1:0] quo_signed;
    logic [XLEN_P-1:0] rem_signed;
    logic [XLEN_P-1:0] quo_final;
    logic [XLEN_P-1:0] rem_final;
    logic              pick_quo;
    logic [XLEN_P-1:0] picked;
    logic [XLEN_P-1:0] result_nxt;

    assign quo_signed = last.neg_quo ? -last.quo : last.quo;
    assign rem_signed = last.neg_rem ? -last.rem : last.rem;

    // Divide by zero: all-ones quotient, dividend as remainder
    assign quo_final = last.div_zero ? '1 : quo_signed;
    assign rem_final = last.div_zero ? last.orig_dividend : rem_signed;

    assign pick_quo = (last.op == OP_DIV) || (last.op == OP_DIVU);
    assign picked   = pick_quo ? quo_final : rem_final;

    // Word forms return a sign-extended low half
    assign result_nxt = last.word ?
                        {{(XLEN_P-WORD_W){picked[WORD_W-1]}}, picked[WORD_W-1:0]} :
                        picked;

    // Whole pipeline holds while a result waits
    assign advance = !(out_valid && !out_ready);

    always_ff @(posedge clk or negedge rst_clk) begin
        if (!rst_clk) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= last.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_tag    <= last.tag;
            out_result <= result_nxt;
        end
    end

endmodule

// File: hdl/div_stage.sv
module div_stage #(
    parameter int XLEN_P           = 64,
    parameter int BITS_PER_STAGE_P = 4
) (
    input  logic          clk,
    input  logic          rst_clk,
    input  logic          flush,
    input  logic          advance,
    div_stage_if.receiver prev,
    div_stage_if.sender   next
);

    logic [XLEN_P-1:0] rem_nxt;
    logic [XLEN_P-1:0] quo_nxt;

    // Restoring steps, one quotient bit each
    always_comb begin
        logic [XLEN_P:0]   shifted;
        logic [XLEN_P+1:0] diff;
        rem_nxt = prev.rem;
        quo_nxt = prev.quo;
        for (int i = 0; i < BITS_PER_STAGE_P; i++) begin
            shifted = {rem_nxt, quo_nxt[XLEN_P-1]};
            diff    = {1'b0, shifted} - {2'b00, prev.divisor};
            if (diff[XLEN_P+1]) begin
                // Borrow, keep the shifted remainder
                rem_nxt = shifted[XLEN_P-1:0];
                quo_nxt = {quo_nxt[XLEN_P-2:0], 1'b0};
            end else begin
                rem_nxt = diff[XLEN_P-1:0];
                quo_nxt = {quo_nxt[XLEN_P-2:0], 1'b1};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_clk) begin
        if (!rst_clk) begin
            next.valid <= 1'b0;
        end else if (flush) begin
            next.valid <= 1'b0;
        end else if (advance) begin
            next.valid <= prev.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            next.tag           <= prev.tag;
            next.op            <= prev.op;
            next.word          <= prev.word;
            next.neg_quo       <= prev.neg_quo;
            next.neg_rem       <= prev.neg_rem;
            next.div_zero      <= prev.div_zero;
            next.orig_dividend <= prev.orig_dividend;
            next.divisor       <= prev.divisor;
            next.rem           <= rem_nxt;
            next.quo           <= quo_nxt;
        end
    end

endmodule

// File: hdl/div_stage_if.sv
interface div_stage_if import div_pkg::*; #(
    parameter int XLEN_P = XLEN
) ();

    logic              valid;
    logic [TAG_W-1:0]  tag;
    div_op_e           op;
    logic              word;
    logic              neg_quo;
    logic              neg_rem;
    logic              div_zero;
    logic [XLEN_P-1:0] orig_dividend;
    logic [XLEN_P-1:0] divisor;
    logic [XLEN_P-1:0] rem;
    // Low bits still hold dividend bits not yet consumed
    logic [XLEN_P-1:0] quo;

    modport sender (
        output valid, tag, op, word, neg_quo, neg_rem, div_zero,
        output orig_dividend, divisor, rem, quo
    );

    modport receiver (
        input valid, tag, op, word, neg_quo, neg_rem, div_zero,
        input orig_dividend, divisor, rem, quo
    );

endinterface

// File: hdl/div_unit.sv
module div_unit import div_pkg::*; #(
    parameter int XLEN_P           = XLEN,
    parameter int BITS_PER_STAGE_P = BITS_PER_STAGE
) (
    input  logic              clk,
    input  logic              rst_clk,
    input  logic              flush,
    input  logic              in_valid,
    output logic              in_ready,
    input  div_op_e           in_op,
    input  logic              in_word,
    input  logic [TAG_W-1:0]  in_tag,
    input  logic [XLEN_P-1:0] in_dividend,
    input  logic [XLEN_P-1:0] in_divisor,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [TAG_W-1:0]  out_tag,
    output logic [XLEN_P-1:0] out_result
);

    localparam int NUM_STAGES_L = XLEN_P / BITS_PER_STAGE_P;

    logic advance;

    // Slot 0 from preparation, slot k+1 from stage k
    div_stage_if #(.XLEN_P(XLEN_P)) slot [NUM_STAGES_L+1] ();

    assign in_ready = advance;

    div_operand_prep #(
        .XLEN_P(XLEN_P)
    ) u_prep (
        .clk        (clk),
        .rst_clk    (rst_clk),
        .flush      (flush),
        .advance    (advance),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_word    (in_word),
        .in_tag     (in_tag),
        .in_dividend(in_dividend),
        .in_divisor (in_divisor),
        .out_slot   (slot[0])
    );

    for (genvar k = 0; k < NUM_STAGES_L; k++) begin : g_stage
        div_stage #(
            .XLEN_P          (XLEN_P),
            .BITS_PER_STAGE_P(BITS_PER_STAGE_P)
        ) u_stage (
            .clk    (clk),
            .rst_clk(rst_clk),
            .flush  (flush),
            .advance(advance),
            .prev   (slot[k]),
            .next   (slot[k+1])
        );
    end

    div_result_fix #(
        .XLEN_P(XLEN_P)
    ) u_fix (
        .clk       (clk),
        .rst_clk   (rst_clk),
        .flush     (flush),
        .last      (slot[NUM_STAGES_L]),
        .out_ready (out_ready),
        .advance   (advance),
        .out_valid (out_valid),
        .out_tag   (out_tag),
        .out_result(out_result)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module div_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdiv_tb +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
exit 1

// File: tests/div_asserts.sv
module div_asserts import div_pkg::*; #(
    parameter int XLEN_P = XLEN
) (
    input logic              clk,
    input logic              rst_clk,
    input logic              flush,
    input logic              in_ready,
    input logic              out_valid,
    input logic              out_ready,
    input logic [TAG_W-1:0]  out_tag,
    input logic [XLEN_P-1:0] out_result
);

    timeunit 1ns;
    timeprecision 100ps;

    int assert_errors;

    initial assert_errors = 0;

    // A waiting result must not move
    hold_stable: assert property (@(posedge clk) disable iff (!rst_clk)
        (out_valid && !out_ready) |=> ($stable(out_result) && $stable(out_tag)))
    else begin
        $error("out_result or out_tag changed while the output was held");
        assert_errors++;
    end

    ready_matches_hold: assert property (@(posedge clk) disable iff (!rst_clk)
        in_ready == !(out_valid && !out_ready))
    else begin
        $error("in_ready does not follow the output hold condition");
        assert_errors++;
    end

    flush_clears_output: assert property (@(posedge clk) disable iff (!rst_clk)
        flush |=> !out_valid)
    else begin
        $error("out_valid still high on the cycle after a flush");
        assert_errors++;
    end

endmodule

// File: tests/div_checker.sv
module div_checker import div_pkg::*; #(
    parameter int XLEN_P           = XLEN,
    parameter int BITS_PER_STAGE_P = BITS_PER_STAGE
) (
    input  logic              clk,
    input  logic              rst_clk,
    input  logic              flush,
    input  logic              in_valid,
    input  logic              in_ready,
    input  div_op_e           in_op,
    input  logic              in_word,
    input  logic [TAG_W-1:0]  in_tag,
    input  logic [XLEN_P-1:0] in_dividend,
    input  logic [XLEN_P-1:0] in_divisor,
    input  logic              out_valid,
    input  logic              out_ready,
    input  logic [TAG_W-1:0]  out_tag,
    input  logic [XLEN_P-1:0] out_result,
    input  logic              ref_valid,
    input  logic [XLEN_P-1:0] ref_result,
    output int                mismatches,
    output int                other_errors,
    output int                pending
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY = XLEN_P / BITS_PER_STAGE_P + 2;

    logic [TAG_W-1:0]  tag_q [$];
    logic [XLEN_P-1:0] res_q [$];
    int                stamp_q [$];
    // Edges on which the pipeline advanced
    int                adv_count;

    function automatic logic [XLEN_P-1:0] word_ext(input logic [31:0] v, input logic sgn);
        return {{(XLEN_P-32){sgn & v[31]}}, v};
    endfunction

    // RISC-V divide rules, including the zero divisor and overflow cases
    function automatic logic [XLEN_P-1:0] predict(input div_op_e           op,
                                                  input logic              word,
                                                  input logic [XLEN_P-1:0] a,
                                                  input logic [XLEN_P-1:0] b);
        logic              sgn;
        logic [XLEN_P-1:0] x;
        logic [XLEN_P-1:0] y;
        logic [XLEN_P-1:0] q;
        logic [XLEN_P-1:0] r;
        logic [XLEN_P-1:0] res;
        sgn = (op == OP_DIV) || (op == OP_REM);
        x = word ? word_ext(a[31:0], sgn) : a;
        y = word ? word_ext(b[31:0], sgn) : b;
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (sgn && x == {1'b1, {(XLEN_P-1){1'b0}}} && y == '1) begin
            q = x;
            r = '0;
        end else if (sgn) begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        res = (op == OP_DIV || op == OP_DIVU) ? q : r;
        return word ? word_ext(res[31:0], 1'b1) : res;
    endfunction

    task automatic report_mismatch(input string name, input logic [XLEN_P-1:0] got,
                                   input logic [XLEN_P-1:0] exp);
        $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        mismatches++;
    endtask

    initial begin
        mismatches   = 0;
        other_errors = 0;
        pending      = 0;
        adv_count    = 0;
    end

    always @(posedge clk) begin
        logic [TAG_W-1:0]  exp_tag;
        logic [XLEN_P-1:0] exp_res;
        logic [XLEN_P-1:0] model;
        int                seen;
        if (!rst_clk || flush) begin
            tag_q.delete();
            res_q.delete();
            stamp_q.delete();
        end else begin
            if (out_valid && out_ready) begin
                if (tag_q.size() == 0) begin
                    $display("ERROR at %0t: result with tag %0d came out with nothing pending",
                             $time, out_tag);
                    other_errors++;
                end else begin
                    exp_tag = tag_q.pop_front();
                    exp_res = res_q.pop_front();
                    // Result was visible one advancing edge before it was taken
                    seen = adv_count - stamp_q.pop_front() - 1;
                    if (out_tag !== exp_tag)
                        report_mismatch("out_tag", XLEN_P'(out_tag), XLEN_P'(exp_tag));
                    if (out_result !== exp_res)
                        report_mismatch("out_result", out_result, exp_res);
                    if (seen != LATENCY)
                        report_mismatch("latency", XLEN_P'(seen), XLEN_P'(LATENCY));
                end
            end
            if (in_valid && in_ready) begin
                model = predict(in_op, in_word, in_dividend, in_divisor);
                if (ref_valid && model !== ref_result)
                    report_mismatch("ref_result", ref_result, model);
                tag_q.push_back(in_tag);
                res_q.push_back(model);
                stamp_q.push_back(adv_count);
            end
            if (in_ready)
                adv_count++;
        end
        pending = tag_q.size();
    end

endmodule

// File: tests/div_tb.sv
module div_tb import div_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;
    localparam int NUM_VEC    = 26;

    typedef struct packed {
        div_op_e         op;
        logic            word;
        logic [XLEN-1:0] dividend;
        logic [XLEN-1:0] divisor;
        logic [XLEN-1:0] expected;
    } vec_t;

    localparam vec_t VECTORS [NUM_VEC] = '{
        '{OP_DIVU, 1'b0, 64'd100, 64'd7, 64'd14},
        '{OP_REMU, 1'b0, 64'd100, 64'd7, 64'd2},
        '{OP_DIVU, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd2, 64'h7FFF_FFFF_FFFF_FFFF},
        '{OP_REMU, 1'b0, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0},
        '{OP_DIVU, 1'b0, 64'h8000_0000_0000_0000, 64'd3, 64'h2AAA_AAAA_AAAA_AAAA},
        '{OP_REMU, 1'b0, 64'h8000_0000_0000_0000, 64'd3, 64'd2},
        // Four sign combinations of 7 and 2
        '{OP_DIV, 1'b0, 64'd7, 64'd2, 64'd3},
        '{OP_DIV, 1'b0, 64'hFFFF_FFFF_FFFF_FFF9, 64'd2, 64'hFFFF_FFFF_FFFF_FFFD},
        '{OP_REM, 1'b0, 64'hFFFF_FFFF_FFFF_FFF9, 64'd2, 64'hFFFF_FFFF_FFFF_FFFF},
        '{OP_DIV, 1'b0, 64'd7, 64'hFFFF_FFFF_FFFF_FFFE, 64'hFFFF_FFFF_FFFF_FFFD},
        '{OP_DIV, 1'b0, 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFFE, 64'd3},
        '{OP_REM, 1'b0, 64'hFFFF_FFFF_FFFF_FFF9, 64'hFFFF_FFFF_FFFF_FFFE, 64'hFFFF_FFFF_FFFF_FFFF},
        // Zero divisor
        '{OP_DIVU, 1'b0, 64'd1234, 64'd0, 64'hFFFF_FFFF_FFFF_FFFF},
        '{OP_REMU, 1'b0, 64'd1234, 64'd0, 64'd1234},
        '{OP_DIV, 1'b0, 64'hFFFF_FFFF_FFFF_FFF9, 64'd0, 64'hFFFF_FFFF_FFFF_FFFF},
        '{OP_REM, 1'b0, 64'hFFFF_FFFF_FFFF_FFF9, 64'd0, 64'hFFFF_FFFF_FFFF_FFF9},
        '{OP_REMU, 1'b1, 64'hAAAA_AAAA_8000_0005, 64'd0, 64'hFFFF_FFFF_8000_0005},
        // Most negative over minus one
        '{OP_DIV, 1'b0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000},
        '{OP_REM, 1'b0, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0},
        '{OP_DIV, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF, 64'hFFFF_FFFF_8000_0000},
        '{OP_REM, 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF, 64'd0},
        // Upper operand halves are ignored by the word forms
        '{OP_DIVU, 1'b1, 64'hDEAD_BEEF_0000_0064, 64'h1234_0000_0000_0007, 64'd14},
        '{OP_DIV, 1'b1, 64'h0000_0001_FFFF_FFF9, 64'h5555_5555_0000_0002, 64'hFFFF_FFFF_FFFF_FFFD},
        '{OP_REM, 1'b1, 64'h0000_0001_FFFF_FFF9, 64'h5555_5555_0000_0002, 64'hFFFF_FFFF_FFFF_FFFF},
        '{OP_DIVU, 1'b1, 64'h0000_0000_FFFF_FFFF, 64'hFFFF_FFFF_0000_0001, 64'hFFFF_FFFF_FFFF_FFFF},
        '{OP_REMU, 1'b1, 64'h7777_7777_FFFF_FFFF, 64'd16, 64'd15}
    };

    logic            clk;
    logic            rst_clk;
    logic            flush;
    logic            in_valid;
    logic            in_ready;
    div_op_e         in_op;
    logic            in_word;
    logic [TAG_W-1:0] in_tag;
    logic [XLEN-1:0] in_dividend;
    logic [XLEN-1:0] in_divisor;
    logic            out_valid;
    logic            out_ready;
    logic [TAG_W-1:0] out_tag;
    logic [XLEN-1:0] out_result;
    logic            ref_valid;
    logic [XLEN-1:0] ref_result;

    logic            random_ready;
    logic [15:0]     lfsr_state;
    logic [TAG_W-1:0] tag_cnt;
    int              tb_errors;
    int              mismatches;
    int              other_errors;
    int              pending;

    div_unit #(
        .XLEN_P          (XLEN),
        .BITS_PER_STAGE_P(BITS_PER_STAGE)
    ) dut (
        .clk        (clk),
        .rst_clk    (rst_clk),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_word    (in_word),
        .in_tag     (in_tag),
        .in_dividend(in_dividend),
        .in_divisor (in_divisor),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_tag    (out_tag),
        .out_result (out_result)
    );

    div_checker #(
        .XLEN_P          (XLEN),
        .BITS_PER_STAGE_P(BITS_PER_STAGE)
    ) chk (
        .clk(clk), .rst_clk(rst_clk), .flush(flush),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op), .in_word(in_word),
        .in_tag(in_tag), .in_dividend(in_dividend), .in_divisor(in_divisor),
        .out_valid(out_valid), .out_ready(out_ready), .out_tag(out_tag),
        .out_result(out_result), .ref_valid(ref_valid), .ref_result(ref_result),
        .mismatches(mismatches), .other_errors(other_errors), .pending(pending)
    );

    bind div_unit div_asserts #(.XLEN_P(XLEN_P)) u_asserts (
        .clk(clk), .rst_clk(rst_clk), .flush(flush), .in_ready(in_ready),
        .out_valid(out_valid), .out_ready(out_ready), .out_tag(out_tag),
        .out_result(out_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [XLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // Moves to the drive point of the next cycle
    task automatic next_cycle();
        logic [XLEN-1:0] bit_v;
        @(posedge clk);
        #5;
        if (random_ready) begin
            take_bits(1, bit_v);
            out_ready = bit_v[0];
        end else begin
            out_ready = 1'b1;
        end
    endtask

    task automatic issue(input div_op_e op, input logic word, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic has_ref,
                         input logic [XLEN-1:0] expected);
        int waited;
        waited      = 0;
        in_valid    = 1'b1;
        in_op       = op;
        in_word     = word;
        in_tag      = tag_cnt;
        in_dividend = a;
        in_divisor  = b;
        ref_valid   = has_ref;
        ref_result  = expected;
        @(negedge clk);
        while (!in_ready && waited < WAIT_LIMIT) begin
            next_cycle();
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("ERROR at %0t: in_ready stayed low for %0d cycles", $time, waited);
            tb_errors++;
        end
        next_cycle();
        in_valid  = 1'b0;
        ref_valid = 1'b0;
        tag_cnt++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (pending != 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("ERROR at %0t: %0d results never came out", $time, pending);
            tb_errors++;
        end
        next_cycle();
    endtask

    task automatic finish_run();
        int total;
        total = mismatches + other_errors + tb_errors + dut.u_asserts.assert_errors;
        $display("Errors: %0d mismatches, %0d checker, %0d testbench, %0d assertion",
                 mismatches, other_errors, tb_errors, dut.u_asserts.assert_errors);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        div_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] w;
        rst_clk      = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_op        = OP_DIV;
        in_word      = 1'b0;
        in_tag       = '0;
        in_dividend  = '0;
        in_divisor   = '0;
        out_ready    = 1'b1;
        ref_valid    = 1'b0;
        ref_result   = '0;
        random_ready = 1'b0;
        lfsr_state   = 16'd4882;
        tag_cnt      = '0;
        tb_errors    = 0;

        repeat (8) @(posedge clk);
        #5;
        rst_clk = 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("MISMATCH at %0t: out_valid got %b expected 0", $time, out_valid);
            tb_errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("MISMATCH at %0t: in_ready got %b expected 1", $time, in_ready);
            tb_errors++;
        end
        next_cycle();

        for (int i = 0; i < NUM_VEC; i++)
            issue(VECTORS[i].op, VECTORS[i].word, VECTORS[i].dividend,
                  VECTORS[i].divisor, 1'b1, VECTORS[i].expected);
        drain();

        // Fill every slot up to the last one, then flush with an operation offered
        for (int i = 0; i < NUM_STAGES + 2; i++)
            issue(VECTORS[i % NUM_VEC].op, VECTORS[i % NUM_VEC].word,
                  VECTORS[i % NUM_VEC].dividend, VECTORS[i % NUM_VEC].divisor, 1'b1,
                  VECTORS[i % NUM_VEC].expected);
        flush = 1'b1;
        issue(VECTORS[5].op, VECTORS[5].word, VECTORS[5].dividend,
              VECTORS[5].divisor, 1'b1, VECTORS[5].expected);
        flush = 1'b0;
        repeat (NUM_STAGES + 4) next_cycle();
        issue(VECTORS[4].op, VECTORS[4].word, VECTORS[4].dividend,
              VECTORS[4].divisor, 1'b1, VECTORS[4].expected);
        drain();

        random_ready = 1'b1;
        for (int n = 0; n < 40; n++) begin
            take_bits(2, r);
            op = div_op_e'(r[1:0]);
            take_bits(1, w);
            take_bits(XLEN, a);
            take_bits(XLEN, b);
            take_bits(6, r);
            b = b >> r[5:0];
            issue(op, w[0], a, b, 1'b0, '0);
        end
        random_ready = 1'b0;
        drain();

        finish_run();
    end

endmodule
